/* design/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // data RAM region, its end depends on RAM_WORDS
    localparam logic [31:0] DATA_RAM_BASE = 32'h0001_0000;

    // GPIO region
    localparam logic [31:0] GPIO_BASE = 32'h0002_0000;
    localparam logic [31:0] GPIO_SIZE = 32'd16;

    // register byte offsets inside the GPIO region
    localparam logic [3:0] GPIO_OUT_OFFSET = 4'h0;
    localparam logic [3:0] GPIO_IN_OFFSET  = 4'h4;

    // slave picked by the address decoder
    typedef enum logic [1:0] {
        SLAVE_NONE,
        SLAVE_RAM,
        SLAVE_GPIO
    } slave_sel_t;

    // arbiter FSM states
    typedef enum logic [1:0] {
        IDLE,
        WAITING_FOR_GRANT,
        WAITING_FOR_RESPONSE
    } bus_state_t;

endpackage

`default_nettype wire

/* design/bus_addr_decoder.sv */
`default_nettype none

module bus_addr_decoder #(
    parameter int RAM_WORDS = 256
) (
    input  wire [31:0]              addr,
    output soc_bus_pkg::slave_sel_t sel
);

    // last byte of each region
    localparam logic [31:0] RAM_END =
        soc_bus_pkg::DATA_RAM_BASE + 32'(4 * RAM_WORDS) - 32'd1;
    localparam logic [31:0] GPIO_END =
        soc_bus_pkg::GPIO_BASE + soc_bus_pkg::GPIO_SIZE - 32'd1;

    logic in_ram;
    logic in_gpio;

    assign in_ram  = (addr >= soc_bus_pkg::DATA_RAM_BASE) && (addr <= RAM_END);
    assign in_gpio = (addr >= soc_bus_pkg::GPIO_BASE) && (addr <= GPIO_END);

    always_comb begin
        if (in_ram) begin
            sel = soc_bus_pkg::SLAVE_RAM;
        end else if (in_gpio) begin
            sel = soc_bus_pkg::SLAVE_GPIO;
        end else begin
            // unmapped, the arbiter answers with an error
            sel = soc_bus_pkg::SLAVE_NONE;
        end
    end

endmodule

`default_nettype wire

/* design/data_bus_arbiter.sv */
`default_nettype none

module data_bus_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,

    // core side
    input  wire                     core_req,
    input  wire                     core_we,
    input  wire [3:0]               core_be,
    input  wire [31:0]              core_addr,
    input  wire [31:0]              core_wdata,
    output logic                    core_gnt,
    output logic                    core_rvalid,
    output logic [31:0]             core_rdata,
    output logic                    core_err,

    // from the decoder
    input  var soc_bus_pkg::slave_sel_t addr_sel,

    // data RAM slave
    output logic                    ram_req,
    output logic                    ram_we,
    output logic [3:0]              ram_be,
    output logic [31:0]             ram_addr,
    output logic [31:0]             ram_wdata,
    input  wire                     ram_gnt,
    input  wire                     ram_rvalid,
    input  wire [31:0]              ram_rdata,

    // GPIO slave
    output logic                    gpio_req,
    output logic                    gpio_we,
    output logic [3:0]              gpio_be,
    output logic [31:0]             gpio_addr,
    output logic [31:0]             gpio_wdata,
    input  wire                     gpio_gnt,
    input  wire                     gpio_rvalid,
    input  wire [31:0]              gpio_rdata
);

    soc_bus_pkg::bus_state_t state, state_d;
    soc_bus_pkg::slave_sel_t sel_q, sel_d;
    soc_bus_pkg::slave_sel_t mux_sel;

    logic        slv_gnt;
    logic        slv_rvalid;
    logic [31:0] slv_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= soc_bus_pkg::IDLE;
            sel_q <= soc_bus_pkg::SLAVE_NONE;
        end else begin
            state <= state_d;
            sel_q <= sel_d;
        end
    end

    always_comb begin
        state_d = state;
        case (state)
            soc_bus_pkg::IDLE: begin
                if (core_req) begin
                    state_d = core_gnt ? soc_bus_pkg::WAITING_FOR_RESPONSE
                                       : soc_bus_pkg::WAITING_FOR_GRANT;
                end
            end
            soc_bus_pkg::WAITING_FOR_GRANT: begin
                if (core_gnt) begin
                    state_d = soc_bus_pkg::WAITING_FOR_RESPONSE;
                end
            end
            soc_bus_pkg::WAITING_FOR_RESPONSE: begin
                if (core_rvalid) begin
                    state_d = soc_bus_pkg::IDLE;
                end
            end
            default: state_d = soc_bus_pkg::IDLE;
        endcase
    end

    // request goes only to the decoded slave, the other one sees zeros
    always_comb begin
        ram_req    = 1'b0;
        ram_we     = 1'b0;
        ram_be     = 4'b0;
        ram_addr   = 32'b0;
        ram_wdata  = 32'b0;
        gpio_req   = 1'b0;
        gpio_we    = 1'b0;
        gpio_be    = 4'b0;
        gpio_addr  = 32'b0;
        gpio_wdata = 32'b0;

        if (core_req && state != soc_bus_pkg::WAITING_FOR_RESPONSE) begin
            case (addr_sel)
                soc_bus_pkg::SLAVE_RAM: begin
                    ram_req   = 1'b1;
                    ram_we    = core_we;
                    ram_be    = core_be;
                    ram_addr  = core_addr;
                    ram_wdata = core_wdata;
                end
                soc_bus_pkg::SLAVE_GPIO: begin
                    gpio_req   = 1'b1;
                    gpio_we    = core_we;
                    gpio_be    = core_be;
                    gpio_addr  = core_addr;
                    gpio_wdata = core_wdata;
                end
                default: ;
            endcase
        end
    end

    // live decode in IDLE, the registered copy once the request is taken
    assign sel_d   = (state == soc_bus_pkg::IDLE && core_req) ? addr_sel : sel_q;
    assign mux_sel = (state == soc_bus_pkg::IDLE) ? addr_sel : sel_q;

    always_comb begin
        slv_gnt    = 1'b0;
        slv_rvalid = 1'b0;
        slv_rdata  = 32'b0;
        case (mux_sel)
            soc_bus_pkg::SLAVE_RAM: begin
                slv_gnt    = ram_gnt;
                slv_rvalid = ram_rvalid;
                slv_rdata  = ram_rdata;
            end
            soc_bus_pkg::SLAVE_GPIO: begin
                slv_gnt    = gpio_gnt;
                slv_rvalid = gpio_rvalid;
                slv_rdata  = gpio_rdata;
            end
            default: ;
        endcase
    end

    always_comb begin
        core_gnt    = 1'b0;
        core_rvalid = slv_rvalid;
        core_rdata  = slv_rdata;
        core_err    = 1'b0;

        case (state)
            soc_bus_pkg::IDLE: begin
                if (core_req) begin
                    // nobody behind an unmapped address, take it right away
                    core_gnt = (mux_sel == soc_bus_pkg::SLAVE_NONE) ? 1'b1 : slv_gnt;
                end
            end
            soc_bus_pkg::WAITING_FOR_GRANT: begin
                core_gnt = slv_gnt;
            end
            soc_bus_pkg::WAITING_FOR_RESPONSE: begin
                if (mux_sel == soc_bus_pkg::SLAVE_NONE) begin
                    core_rvalid = 1'b1;
                    core_rdata  = 32'b0;
                    core_err    = 1'b1;
                end
            end
            default: ;
        endcase
    end

    unmapped_access: assert property (@(posedge clk) disable iff (!rst_n)
        core_req |-> addr_sel != soc_bus_pkg::SLAVE_NONE)
    else
        $warning("unmapped address requested: 0x%08x", core_addr);

    // a slave answering out of turn would show up here
    rvalid_in_response_state: assert property (@(posedge clk) disable iff (!rst_n)
        core_rvalid |-> state == soc_bus_pkg::WAITING_FOR_RESPONSE)
    else
        $error("rvalid to the core outside WAITING_FOR_RESPONSE");

    gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(core_gnt) |-> core_req)
    else
        $error("core_gnt raised without core_req");

endmodule

`default_nettype wire

/* design/data_ram.sv */
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         req,
    input  wire         we,
    input  wire  [3:0]  be,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    output logic        gnt,
    output logic        rvalid,
    output logic [31:0] rdata
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] word_idx;
    logic [31:0]   rdata_q;
    logic          rvalid_q;

    // word address wraps around the array size
    assign word_idx = AW'(addr[31:2] % RAM_WORDS);

    // always ready
    assign gnt = req;

    always_ff @(posedge clk) begin
        if (req && gnt && we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read data captured at grant and zero for writes
    always_ff @(posedge clk) begin
        if (req && gnt) begin
            rdata_q <= we ? 32'b0 : mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req && gnt;
        end
    end

    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

/* design/gpio_port.sv */
`default_nettype none

module gpio_port #(
    parameter int GPIO_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   req,
    input  wire                   we,
    input  wire  [3:0]            be,
    input  wire  [31:0]           addr,
    input  wire  [31:0]           wdata,
    output logic                  gnt,
    output logic                  rvalid,
    output logic [31:0]           rdata,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    input  wire  [GPIO_WIDTH-1:0] gpio_in
);

    logic                  pending;
    logic                  rvalid_q;
    logic [31:0]           rdata_q;
    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_q;
    logic [31:0]           out_merged;
    logic                  sel_out;
    logic                  sel_in;

    assign sel_out = (addr[3:0] == soc_bus_pkg::GPIO_OUT_OFFSET);
    assign sel_in  = (addr[3:0] == soc_bus_pkg::GPIO_IN_OFFSET);

    // grant on the second cycle of req after one wait cycle
    assign gnt = req && pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            pending  <= req && !pending;
            rvalid_q <= gnt;
        end
    end

    // byte lane merge into the output register
    always_comb begin
        out_merged = 32'(out_q);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                out_merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (gnt && we && sel_out) begin
            out_q <= out_merged[GPIO_WIDTH-1:0];
        end
    end

    // two-flop synchronizer for the pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_q    <= '0;
        end else begin
            in_meta <= gpio_in;
            in_q    <= in_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (gnt) begin
            if (we) begin
                rdata_q <= 32'b0;
            end else if (sel_out) begin
                rdata_q <= 32'(out_q);
            end else if (sel_in) begin
                rdata_q <= 32'(in_q);
            end else begin
                rdata_q <= 32'b0;
            end
        end
    end

    assign rvalid   = rvalid_q;
    assign rdata    = rdata_q;
    assign gpio_out = out_q;

endmodule

`default_nettype wire

/* design/bus_subsystem_top.sv */
`default_nettype none

module bus_subsystem_top #(
    parameter int RAM_WORDS  = 256,
    parameter int GPIO_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   core_req,
    input  wire                   core_we,
    input  wire  [3:0]            core_be,
    input  wire  [31:0]           core_addr,
    input  wire  [31:0]           core_wdata,
    output logic                  core_gnt,
    output logic                  core_rvalid,
    output logic [31:0]           core_rdata,
    output logic                  core_err,

    output logic [GPIO_WIDTH-1:0] gpio_out,
    input  wire  [GPIO_WIDTH-1:0] gpio_in
);

    soc_bus_pkg::slave_sel_t addr_sel;

    logic        ram_req;
    logic        ram_we;
    logic [3:0]  ram_be;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic        ram_gnt;
    logic        ram_rvalid;
    logic [31:0] ram_rdata;

    logic        gpio_req;
    logic        gpio_we;
    logic [3:0]  gpio_be;
    logic [31:0] gpio_addr;
    logic [31:0] gpio_wdata;
    logic        gpio_gnt;
    logic        gpio_rvalid;
    logic [31:0] gpio_rdata;

    bus_addr_decoder #(
        .RAM_WORDS (RAM_WORDS)
    ) u_decoder (
        .addr (core_addr),
        .sel  (addr_sel)
    );

    data_bus_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_req    (core_req),
        .core_we     (core_we),
        .core_be     (core_be),
        .core_addr   (core_addr),
        .core_wdata  (core_wdata),
        .core_gnt    (core_gnt),
        .core_rvalid (core_rvalid),
        .core_rdata  (core_rdata),
        .core_err    (core_err),
        .addr_sel    (addr_sel),
        .ram_req     (ram_req),
        .ram_we      (ram_we),
        .ram_be      (ram_be),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_gnt     (ram_gnt),
        .ram_rvalid  (ram_rvalid),
        .ram_rdata   (ram_rdata),
        .gpio_req    (gpio_req),
        .gpio_we     (gpio_we),
        .gpio_be     (gpio_be),
        .gpio_addr   (gpio_addr),
        .gpio_wdata  (gpio_wdata),
        .gpio_gnt    (gpio_gnt),
        .gpio_rvalid (gpio_rvalid),
        .gpio_rdata  (gpio_rdata)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (ram_req),
        .we     (ram_we),
        .be     (ram_be),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .gnt    (ram_gnt),
        .rvalid (ram_rvalid),
        .rdata  (ram_rdata)
    );

    gpio_port #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (gpio_req),
        .we       (gpio_we),
        .be       (gpio_be),
        .addr     (gpio_addr),
        .wdata    (gpio_wdata),
        .gnt      (gpio_gnt),
        .rvalid   (gpio_rvalid),
        .rdata    (gpio_rdata),
        .gpio_out (gpio_out),
        .gpio_in  (gpio_in)
    );

endmodule

`default_nettype wire

/* verification/tb_bus_subsystem.sv */
`default_nettype none

module tb_bus_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_WORDS   = 256;
    localparam int GPIO_WIDTH  = 8;
    localparam int AW          = $clog2(RAM_WORDS);
    localparam int N_DIRECTED  = 17;
    localparam int N_RANDOM    = 32;
    localparam int MAX_TESTS   = N_DIRECTED + 2 * N_RANDOM;
    // reset, ten cycles per access, then some slack
    localparam int CYCLE_LIMIT = 8 + 10 * MAX_TESTS + 50;

    localparam logic [31:0] RAM_BASE = soc_bus_pkg::DATA_RAM_BASE;
    localparam logic [31:0] RAM_LAST = RAM_BASE + 32'(4 * RAM_WORDS) - 32'd1;
    localparam logic [31:0] GPIO_OUT = soc_bus_pkg::GPIO_BASE + 32'(soc_bus_pkg::GPIO_OUT_OFFSET);
    localparam logic [31:0] GPIO_IN  = soc_bus_pkg::GPIO_BASE + 32'(soc_bus_pkg::GPIO_IN_OFFSET);

    typedef struct {
        string                 name;
        logic                  we;
        logic [3:0]            be;
        logic [31:0]           addr;
        logic [31:0]           wdata;
        logic [GPIO_WIDTH-1:0] gin;
        logic [31:0]           exp_rdata;
        logic [31:0]           exp_mask;
        logic                  exp_err;
        int                    exp_gnt_cycle;
        logic [GPIO_WIDTH-1:0] exp_gpio_out;
    } access_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  core_req;
    logic                  core_we;
    logic [3:0]            core_be;
    logic [31:0]           core_addr;
    logic [31:0]           core_wdata;
    logic                  core_gnt;
    logic                  core_rvalid;
    logic [31:0]           core_rdata;
    logic                  core_err;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_in;

    access_t               tests [MAX_TESTS];
    int                    n_tests = 0;
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    test_errs = 0;
    int                    cycle_count = 0;
    logic [31:0]           lfsr_state = 32'h4669cfd7;

    // reference model state
    logic [31:0]           model_ram [RAM_WORDS];
    logic [31:0]           model_known [RAM_WORDS];
    logic [GPIO_WIDTH-1:0] model_out;

    bus_subsystem_top #(
        .RAM_WORDS  (RAM_WORDS),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_req    (core_req),
        .core_we     (core_we),
        .core_be     (core_be),
        .core_addr   (core_addr),
        .core_wdata  (core_wdata),
        .core_gnt    (core_gnt),
        .core_rvalid (core_rvalid),
        .core_rdata  (core_rdata),
        .core_err    (core_err),
        .gpio_out    (gpio_out),
        .gpio_in     (gpio_in)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timed out waiting for grant or response");
            $display("tests failed");
            $finish;
        end
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        out_bit;
        val = '0;
        for (int k = 0; k < n; k++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            val[k] = out_bit;
        end
        return val;
    endfunction

    // runs the model for one access and appends it with its expected response
    task automatic add_entry(input string name, input logic we, input logic [3:0] be,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [GPIO_WIDTH-1:0] gin);
        access_t     e;
        int          idx;
        logic [31:0] off;
        logic [31:0] out_ext;
        e.name          = name;
        e.we            = we;
        e.be            = be;
        e.addr          = addr;
        e.wdata         = wdata;
        e.gin           = gin;
        e.exp_rdata     = 32'b0;
        e.exp_mask      = 32'hffff_ffff;
        e.exp_err       = 1'b0;
        e.exp_gnt_cycle = 0;
        if (addr >= RAM_BASE && addr <= RAM_LAST) begin
            idx = int'((addr >> 2) % RAM_WORDS);
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        model_ram[idx][8*i +: 8]   = wdata[8*i +: 8];
                        model_known[idx][8*i +: 8] = 8'hff;
                    end
                end
            end else begin
                // bytes never written are left out of the compare
                e.exp_rdata = model_ram[idx];
                e.exp_mask  = model_known[idx];
            end
        end else if (addr >= soc_bus_pkg::GPIO_BASE &&
                     addr < soc_bus_pkg::GPIO_BASE + soc_bus_pkg::GPIO_SIZE) begin
            e.exp_gnt_cycle = 1;
            off     = addr - soc_bus_pkg::GPIO_BASE;
            out_ext = 32'(model_out);
            if (we) begin
                if (off == 32'(soc_bus_pkg::GPIO_OUT_OFFSET)) begin
                    for (int i = 0; i < 4; i++) begin
                        if (be[i]) begin
                            out_ext[8*i +: 8] = wdata[8*i +: 8];
                        end
                    end
                    model_out = out_ext[GPIO_WIDTH-1:0];
                end
            end else if (off == 32'(soc_bus_pkg::GPIO_OUT_OFFSET)) begin
                e.exp_rdata = out_ext;
            end else if (off == 32'(soc_bus_pkg::GPIO_IN_OFFSET)) begin
                e.exp_rdata = 32'(gin);
            end
        end else begin
            e.exp_err = 1'b1;
        end
        e.exp_gpio_out   = model_out;
        tests[n_tests] = e;
        n_tests++;
    endtask

    task automatic build_table();
        logic [31:0]     word;
        logic [31:0]     bits;
        logic [31:0]     rand_addr [N_RANDOM];
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_known[i] = 32'b0;
        end
        model_out = '0;
        add_entry("ram_write_full", 1'b1, 4'hf, RAM_BASE + 32'h10, 32'hdeadbeef, 8'h5a);
        add_entry("ram_read_full", 1'b0, 4'hf, RAM_BASE + 32'h10, 32'h0, 8'h5a);
        add_entry("be_write_byte1", 1'b1, 4'b0010, RAM_BASE + 32'h10, 32'h11223344, 8'h5a);
        add_entry("be_write_upper", 1'b1, 4'b1100, RAM_BASE + 32'h10, 32'ha5a55a5a, 8'h5a);
        add_entry("be_read_merged", 1'b0, 4'hf, RAM_BASE + 32'h10, 32'h0, 8'h5a);
        add_entry("ram_write_last", 1'b1, 4'hf, RAM_LAST - 32'd3, 32'h0badf00d, 8'h5a);
        add_entry("ram_read_last", 1'b0, 4'hf, RAM_LAST - 32'd3, 32'h0, 8'h5a);
        add_entry("gpio_write_out", 1'b1, 4'hf, GPIO_OUT, 32'h123456c3, 8'h5a);
        add_entry("gpio_read_out", 1'b0, 4'hf, GPIO_OUT, 32'h0, 8'h5a);
        add_entry("gpio_read_in", 1'b0, 4'hf, GPIO_IN, 32'h0, 8'h5a);
        add_entry("gpio_write_in_ignored", 1'b1, 4'hf, GPIO_IN, 32'hffffffff, 8'h5a);
        add_entry("gpio_read_out_after", 1'b0, 4'hf, GPIO_OUT, 32'h0, 8'h5a);
        add_entry("gpio_read_in_after", 1'b0, 4'hf, GPIO_IN, 32'h0, 8'h3c);
        add_entry("gpio_write_out_byte1", 1'b1, 4'b0010, GPIO_OUT, 32'h0000ff00, 8'h3c);
        add_entry("unmapped_read", 1'b0, 4'hf, 32'h0003_0000, 32'h0, 8'h3c);
        add_entry("unmapped_write", 1'b1, 4'hf, 32'h0000_0100, 32'h77777777, 8'h3c);
        add_entry("ram_after_unmapped", 1'b0, 4'hf, RAM_BASE + 32'h10, 32'h0, 8'h3c);
        for (int i = 0; i < N_RANDOM; i++) begin
            word         = lfsr_bits(AW);
            rand_addr[i] = RAM_BASE + (word << 2);
            bits         = lfsr_bits(4);
            add_entry($sformatf("rand_write_%0d", i), 1'b1, bits[3:0], rand_addr[i],
                      lfsr_bits(32), 8'h3c);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            add_entry($sformatf("rand_read_%0d", i), 1'b0, 4'hf, rand_addr[i], 32'h0, 8'h3c);
        end
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Mismatch %s %s expected 0x%08x actual 0x%08x", name, what, expected, actual);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s", name);
            fail_count++;
        end
        test_errs = 0;
    endtask

    task automatic apply_access(input int i);
        int          cycle;
        int          gnt_cycle;
        int          rvalid_cycle;
        logic [31:0] rdata;
        logic        err;
        @(negedge clk);
        gpio_in = tests[i].gin;
        // let the pins pass the synchronizer
        repeat (3) @(negedge clk);
        core_req   = 1'b1;
        core_we    = tests[i].we;
        core_be    = tests[i].be;
        core_addr  = tests[i].addr;
        core_wdata = tests[i].wdata;
        cycle      = 0;
        gnt_cycle  = -1;
        while (gnt_cycle < 0) begin
            @(posedge clk);
            if (core_gnt) begin
                gnt_cycle = cycle;
            end
            cycle++;
        end
        @(negedge clk);
        core_req     = 1'b0;
        core_we      = 1'b0;
        core_be      = 4'b0;
        core_addr    = 32'b0;
        core_wdata   = 32'b0;
        rvalid_cycle = -1;
        while (rvalid_cycle < 0) begin
            @(posedge clk);
            if (core_rvalid) begin
                rvalid_cycle = cycle;
                rdata        = core_rdata;
                err          = core_err;
            end
            cycle++;
        end
        if (gnt_cycle != tests[i].exp_gnt_cycle) begin
            report_mismatch(tests[i].name, "gnt cycle", 32'(tests[i].exp_gnt_cycle),
                            32'(gnt_cycle));
        end
        if (rvalid_cycle != gnt_cycle + 1) begin
            report_mismatch(tests[i].name, "rvalid cycle", 32'(gnt_cycle + 1),
                            32'(rvalid_cycle));
        end
        if ((rdata & tests[i].exp_mask) !== (tests[i].exp_rdata & tests[i].exp_mask)) begin
            report_mismatch(tests[i].name, "rdata", tests[i].exp_rdata & tests[i].exp_mask,
                            rdata & tests[i].exp_mask);
        end
        if (err !== tests[i].exp_err) begin
            report_mismatch(tests[i].name, "err", 32'(tests[i].exp_err), 32'(err));
        end
        if (gpio_out !== tests[i].exp_gpio_out) begin
            report_mismatch(tests[i].name, "gpio_out", 32'(tests[i].exp_gpio_out),
                            32'(gpio_out));
        end
        finish_test(tests[i].name);
    endtask

    initial begin
        rst_n      = 1'b0;
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_be    = 4'b0;
        core_addr  = 32'b0;
        core_wdata = 32'b0;
        gpio_in    = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        if ({core_gnt, core_rvalid, core_err} !== 3'b000) begin
            report_mismatch("reset_values", "gnt/rvalid/err", 32'b0,
                            32'({core_gnt, core_rvalid, core_err}));
        end
        if (gpio_out !== '0) begin
            report_mismatch("reset_values", "gpio_out", 32'b0, 32'(gpio_out));
        end
        finish_test("reset_values");
        for (int i = 0; i < n_tests; i++) begin
            apply_access(i);
        end
        @(negedge clk);
        $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/soc_bus_pkg.sv
design/bus_addr_decoder.sv
design/data_bus_arbiter.sv
design/data_ram.sv
design/gpio_port.sv
design/bus_subsystem_top.sv
verification/tb_bus_subsystem.sv

/* Makefile */
SIM := obj_dir/Vtb_bus_subsystem
LOG := sim.log

.PHONY: all run lint clean

all: run

$(SIM): src.f $(wildcard design/*.sv verification/*.sv)
	verilator --binary --timing --assert -f src.f --top-module tb_bus_subsystem \
		-o Vtb_bus_subsystem

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module tb_bus_subsystem

clean:
	rm -rf obj_dir $(LOG)
